/* rtl/core_pkg.sv */
package core_pkg;

    // Datapath sizes
    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 16;
    localparam int REG_AW     = 4;
    localparam int DMEM_WORDS = 16;
    localparam int DMEM_AW    = 4;

    // Instruction field positions
    localparam int COND_MSB     = 31;
    localparam int COND_LSB     = 28;
    localparam int TYPE_MSB     = 27;
    localparam int TYPE_LSB     = 26;
    localparam int IMM_FLAG_BIT = 25;
    localparam int OPC_MSB      = 24;
    localparam int OPC_LSB      = 21;
    localparam int LOAD_BIT     = 20;
    localparam int RN_LSB       = 16;
    localparam int RD_LSB       = 12;
    localparam int RM_LSB       = 0;
    localparam int IMM8_WIDTH   = 8;
    localparam int OFFSET_WIDTH = 24;   // Branch offset in bits 23..0

    localparam logic [1:0] TYPE_DATA       = 2'b00;
    localparam logic [1:0] TYPE_LOAD_STORE = 2'b01;
    localparam logic [1:0] TYPE_BRANCH     = 2'b10;

    localparam logic [3:0] OPC_AND  = 4'b0000;
    localparam logic [3:0] OPC_ANDS = 4'b0001;
    localparam logic [3:0] OPC_SUB  = 4'b0010;
    localparam logic [3:0] OPC_SUBS = 4'b0011;
    localparam logic [3:0] OPC_ADD  = 4'b0100;
    localparam logic [3:0] OPC_LSL  = 4'b1101;

    localparam logic [1:0] STATUS_UPDATE = 2'b11;   // Update N and Z

    localparam logic [3:0] COND_NE = 4'b0001;
    localparam logic [3:0] COND_LE = 4'b1101;   // Z or N, no V flag
    localparam logic [3:0] COND_AL = 4'b1110;

    typedef enum logic [1:0] {
        ALU_AND = 2'b00,
        ALU_ADD = 2'b01,
        ALU_SUB = 2'b10,
        ALU_LSL = 2'b11
    } alu_op_t;

endpackage

/* rtl/control_unit.sv */
`timescale 1ns/1ps

module control_unit
    import core_pkg::*;
(
    input  logic [XLEN-1:0] instruction,
    output logic            reg_write_enable,
    output logic            mem_write_enable,
    output logic            mem_to_reg_select,
    output logic            alu_source_select,   // 1 selects the 8-bit immediate
    output logic [1:0]      status_bits,
    output alu_op_t         alu_operation,
    output logic            pc_source_select     // Set for branch type
);

    logic [1:0] op_type;
    logic [3:0] opcode;
    logic       imm_flag;
    logic       load_bit;

    assign op_type  = instruction[TYPE_MSB:TYPE_LSB];
    assign opcode   = instruction[OPC_MSB:OPC_LSB];
    assign imm_flag = instruction[IMM_FLAG_BIT];
    assign load_bit = instruction[LOAD_BIT];

    always_comb begin
        reg_write_enable  = 1'b0;
        mem_write_enable  = 1'b0;
        mem_to_reg_select = 1'b0;
        alu_source_select = 1'b0;
        status_bits       = 2'b00;
        alu_operation     = ALU_ADD;
        pc_source_select  = 1'b0;

        case (op_type)
            TYPE_DATA: begin
                reg_write_enable  = 1'b1;
                alu_source_select = imm_flag;
                case (opcode)
                    OPC_AND:  alu_operation = ALU_AND;
                    OPC_ANDS: begin
                        alu_operation = ALU_AND;
                        status_bits   = STATUS_UPDATE;
                    end
                    OPC_SUB:  alu_operation = ALU_SUB;
                    OPC_SUBS: begin
                        alu_operation = ALU_SUB;
                        status_bits   = STATUS_UPDATE;
                    end
                    OPC_ADD:  alu_operation = ALU_ADD;
                    OPC_LSL:  alu_operation = ALU_LSL;
                    default:  alu_operation = ALU_ADD;   // Unlisted opcodes add
                endcase
            end
            TYPE_LOAD_STORE: begin
                alu_source_select = 1'b1;   // Address is rn + imm8
                alu_operation     = ALU_ADD;
                if (load_bit) begin
                    reg_write_enable  = 1'b1;   // LDRB
                    mem_to_reg_select = 1'b1;
                end else begin
                    mem_write_enable = 1'b1;    // STR
                end
            end
            TYPE_BRANCH: pc_source_select = 1'b1;
            default: ;   // Type 11 does nothing
        endcase

        // All-zero word is a NOP whatever the fields say
        if (instruction == '0) begin
            reg_write_enable  = 1'b0;
            mem_write_enable  = 1'b0;
            mem_to_reg_select = 1'b0;
            alu_source_select = 1'b0;
            status_bits       = 2'b00;
            alu_operation     = ALU_ADD;
            pc_source_select  = 1'b0;
        end
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] rd_addr_a,
    input  logic [REG_AW-1:0] rd_addr_b,
    input  logic              wr_enable,
    input  logic [REG_AW-1:0] wr_addr,
    input  logic [XLEN-1:0]   wr_data,
    output logic [XLEN-1:0]   rd_data_a,
    output logic [XLEN-1:0]   rd_data_b
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_enable) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so a same-cycle reader sees the new value
    assign rd_data_a = (wr_enable && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_enable && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  logic [XLEN-1:0]          instruction,
    input  logic [XLEN-1:0]          rd_data_a,
    input  logic [XLEN-1:0]          rd_data_b,
    output logic [REG_AW-1:0]        rd_addr_a,
    output logic [REG_AW-1:0]        rd_addr_b,
    output logic                     d_valid,
    output logic                     d_reg_write,
    output logic                     d_mem_write,
    output logic                     d_mem_to_reg,
    output logic [1:0]               d_status,
    output alu_op_t                  d_alu_op,
    output logic                     d_branch,
    output logic [XLEN-1:0]          d_op_a,
    output logic [XLEN-1:0]          d_op_b,
    output logic [XLEN-1:0]          d_store_data,
    output logic [REG_AW-1:0]        d_rd,
    output logic [COND_MSB-COND_LSB:0] d_cond,
    output logic [OFFSET_WIDTH-1:0]  d_offset
);

    logic              reg_write_enable;
    logic              mem_write_enable;
    logic              mem_to_reg_select;
    logic              alu_source_select;
    logic [1:0]        status_bits;
    alu_op_t           alu_operation;
    logic              pc_source_select;
    logic [REG_AW-1:0] rd_field;
    logic [XLEN-1:0]   imm_ext;

    control_unit control_unit_i (
        .instruction       (instruction),
        .reg_write_enable  (reg_write_enable),
        .mem_write_enable  (mem_write_enable),
        .mem_to_reg_select (mem_to_reg_select),
        .alu_source_select (alu_source_select),
        .status_bits       (status_bits),
        .alu_operation     (alu_operation),
        .pc_source_select  (pc_source_select)
    );

    assign rd_field  = instruction[RD_LSB +: REG_AW];
    assign rd_addr_a = instruction[RN_LSB +: REG_AW];
    assign rd_addr_b = mem_write_enable ? rd_field : instruction[RM_LSB +: REG_AW];   // Store reads rd
    assign imm_ext   = {{(XLEN-IMM8_WIDTH){1'b0}}, instruction[IMM8_WIDTH-1:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid      <= 1'b0;
            d_reg_write  <= 1'b0;
            d_mem_write  <= 1'b0;
            d_mem_to_reg <= 1'b0;
            d_status     <= 2'b00;
            d_alu_op     <= ALU_ADD;
            d_branch     <= 1'b0;
        end else begin
            d_valid      <= instr_valid && (instruction != '0);   // NOP never enters
            d_reg_write  <= reg_write_enable;
            d_mem_write  <= mem_write_enable;
            d_mem_to_reg <= mem_to_reg_select;
            d_status     <= status_bits;
            d_alu_op     <= alu_operation;
            d_branch     <= pc_source_select;
        end
    end

    always_ff @(posedge clk) begin
        d_op_a       <= rd_data_a;
        d_op_b       <= alu_source_select ? imm_ext : rd_data_b;
        d_store_data <= rd_data_b;
        d_rd         <= rd_field;
        d_cond       <= instruction[COND_MSB:COND_LSB];
        d_offset     <= instruction[OFFSET_WIDTH-1:0];
    end

    // Load and store are exclusive per instruction
    a_no_load_and_store: assert property (@(posedge clk) disable iff (!rst_n)
        d_valid |-> !(d_mem_to_reg && d_mem_write))
        else $error("decode holds a load and a store at once");

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       d_valid,
    input  logic                       d_reg_write,
    input  logic                       d_mem_write,
    input  logic                       d_mem_to_reg,
    input  logic [1:0]                 d_status,
    input  alu_op_t                    d_alu_op,
    input  logic                       d_branch,
    input  logic [XLEN-1:0]            d_op_a,
    input  logic [XLEN-1:0]            d_op_b,
    input  logic [XLEN-1:0]            d_store_data,
    input  logic [REG_AW-1:0]          d_rd,
    input  logic [COND_MSB-COND_LSB:0] d_cond,
    input  logic [OFFSET_WIDTH-1:0]    d_offset,
    output logic                       e_valid,
    output logic [XLEN-1:0]            e_result,
    output logic [XLEN-1:0]            e_store_data,
    output logic [REG_AW-1:0]          e_rd,
    output logic                       e_reg_write,
    output logic                       e_mem_write,
    output logic                       e_mem_to_reg,
    output logic                       branch_taken,
    output logic [OFFSET_WIDTH-1:0]    branch_offset,
    output logic                       flag_n,
    output logic                       flag_z
);

    logic [XLEN-1:0] alu_result;
    logic            cond_pass;

    always_comb begin
        case (d_alu_op)
            ALU_AND: alu_result = d_op_a & d_op_b;
            ALU_SUB: alu_result = d_op_a - d_op_b;
            ALU_LSL: alu_result = d_op_a << d_op_b[$clog2(XLEN)-1:0];   // Low 5 bits only
            default: alu_result = d_op_a + d_op_b;
        endcase
    end

    // Condition checked against flags before this instruction
    always_comb begin
        case (d_cond)
            COND_NE: cond_pass = !flag_z;
            COND_LE: cond_pass = flag_z || flag_n;
            COND_AL: cond_pass = 1'b1;
            default: cond_pass = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            e_valid      <= 1'b0;
            e_reg_write  <= 1'b0;
            e_mem_write  <= 1'b0;
            e_mem_to_reg <= 1'b0;
            branch_taken <= 1'b0;
            flag_n       <= 1'b0;
            flag_z       <= 1'b0;
        end else begin
            e_valid      <= d_valid;
            e_reg_write  <= d_valid && d_reg_write;
            e_mem_write  <= d_valid && d_mem_write;
            e_mem_to_reg <= d_mem_to_reg;
            branch_taken <= d_valid && d_branch && cond_pass;   // One-cycle pulse
            if (d_valid && d_status == STATUS_UPDATE) begin
                flag_n <= alu_result[XLEN-1];
                flag_z <= (alu_result == '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        e_result      <= alu_result;
        e_store_data  <= d_store_data;
        e_rd          <= d_rd;
        branch_offset <= d_offset;
    end

    a_branch_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        branch_taken |-> !e_reg_write)
        else $error("taken branch also writes a register");

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage
    import core_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              e_valid,
    input  logic [XLEN-1:0]   e_result,
    input  logic [XLEN-1:0]   e_store_data,
    input  logic [REG_AW-1:0] e_rd,
    input  logic              e_reg_write,
    input  logic              e_mem_write,
    input  logic              e_mem_to_reg,
    output logic              wb_valid,
    output logic [REG_AW-1:0] wb_reg,
    output logic [XLEN-1:0]   wb_data
);

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [1:0]         byte_sel;
    logic [XLEN-1:0]    rd_word;
    logic [7:0]         load_byte;
    logic               st_valid;   // Store pending, lands with writeback
    logic [DMEM_AW-1:0] st_idx;
    logic [XLEN-1:0]    st_data;

    assign word_idx  = e_result[DMEM_AW+1:2];
    assign byte_sel  = e_result[1:0];
    assign rd_word   = dmem[word_idx];
    assign load_byte = rd_word[{byte_sel, 3'b000} +: 8];   // Little-endian byte lanes

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            st_valid <= 1'b0;
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else begin
            wb_valid <= e_valid && e_reg_write;
            st_valid <= e_valid && e_mem_write;
            if (st_valid) begin
                dmem[st_idx] <= st_data;   // Whole word store
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= e_rd;
        wb_data <= e_mem_to_reg ? {{(XLEN-8){1'b0}}, load_byte} : e_result;
        st_idx  <= word_idx;
        st_data <= e_store_data;
    end

    a_wb_not_store: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> !st_valid)
        else $error("writeback and store from one instruction");

endmodule

/* rtl/core_top.sv */
`timescale 1ns/1ps

module core_top
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,
    input  logic [XLEN-1:0]         instruction,
    output logic                    wb_valid,
    output logic [REG_AW-1:0]       wb_reg,
    output logic [XLEN-1:0]         wb_data,
    output logic                    branch_taken,
    output logic [OFFSET_WIDTH-1:0] branch_offset,
    output logic                    flag_n,
    output logic                    flag_z
);

    logic [REG_AW-1:0]          rd_addr_a;
    logic [REG_AW-1:0]          rd_addr_b;
    logic [XLEN-1:0]            rd_data_a;
    logic [XLEN-1:0]            rd_data_b;
    logic                       d_valid;
    logic                       d_reg_write;
    logic                       d_mem_write;
    logic                       d_mem_to_reg;
    logic [1:0]                 d_status;
    alu_op_t                    d_alu_op;
    logic                       d_branch;
    logic [XLEN-1:0]            d_op_a;
    logic [XLEN-1:0]            d_op_b;
    logic [XLEN-1:0]            d_store_data;
    logic [REG_AW-1:0]          d_rd;
    logic [COND_MSB-COND_LSB:0] d_cond;
    logic [OFFSET_WIDTH-1:0]    d_offset;
    logic                       e_valid;
    logic [XLEN-1:0]            e_result;
    logic [XLEN-1:0]            e_store_data;
    logic [REG_AW-1:0]          e_rd;
    logic                       e_reg_write;
    logic                       e_mem_write;
    logic                       e_mem_to_reg;

    decode_stage decode_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instruction  (instruction),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .d_valid      (d_valid),
        .d_reg_write  (d_reg_write),
        .d_mem_write  (d_mem_write),
        .d_mem_to_reg (d_mem_to_reg),
        .d_status     (d_status),
        .d_alu_op     (d_alu_op),
        .d_branch     (d_branch),
        .d_op_a       (d_op_a),
        .d_op_b       (d_op_b),
        .d_store_data (d_store_data),
        .d_rd         (d_rd),
        .d_cond       (d_cond),
        .d_offset     (d_offset)
    );

    execute_stage execute_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_valid       (d_valid),
        .d_reg_write   (d_reg_write),
        .d_mem_write   (d_mem_write),
        .d_mem_to_reg  (d_mem_to_reg),
        .d_status      (d_status),
        .d_alu_op      (d_alu_op),
        .d_branch      (d_branch),
        .d_op_a        (d_op_a),
        .d_op_b        (d_op_b),
        .d_store_data  (d_store_data),
        .d_rd          (d_rd),
        .d_cond        (d_cond),
        .d_offset      (d_offset),
        .e_valid       (e_valid),
        .e_result      (e_result),
        .e_store_data  (e_store_data),
        .e_rd          (e_rd),
        .e_reg_write   (e_reg_write),
        .e_mem_write   (e_mem_write),
        .e_mem_to_reg  (e_mem_to_reg),
        .branch_taken  (branch_taken),
        .branch_offset (branch_offset),
        .flag_n        (flag_n),
        .flag_z        (flag_z)
    );

    memory_stage memory_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .e_valid      (e_valid),
        .e_result     (e_result),
        .e_store_data (e_store_data),
        .e_rd         (e_rd),
        .e_reg_write  (e_reg_write),
        .e_mem_write  (e_mem_write),
        .e_mem_to_reg (e_mem_to_reg),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data)
    );

    // Writeback register doubles as the register file write port
    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_enable (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

endmodule

/* testbench/core_tb.sv */
`timescale 1ns/1ps

module core_tb
    import core_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int N_RESET      = 16;
    localparam int N_DATA       = 60;
    localparam int N_FLAGS      = 40;
    localparam int N_MEM        = 21;   // Base setup plus four words of STR and LDRB x4
    localparam int N_BRANCH     = 60;
    localparam int N_QUIET      = 20;
    localparam int N_RANDOM     = 200;
    localparam int NUM_TESTS    = 7;
    localparam int TOTAL_INSTR  = N_RESET + N_DATA + N_FLAGS + N_MEM + N_BRANCH + N_QUIET
                                  + N_RANDOM;
    // Three slots per instruction plus reset and a short drain per test
    localparam int TIMEOUT_CYCLES = 3 * TOTAL_INSTR + RESET_CYCLES + 4 * NUM_TESTS + 50;

    typedef struct packed {
        int          due;
        logic [3:0]  rg;
        logic [31:0] data;
    } wb_event_t;

    typedef struct packed {
        int          due;
        logic [23:0] off;
    } br_event_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instruction;
    logic        wb_valid;
    logic [3:0]  wb_reg;
    logic [31:0] wb_data;
    logic        branch_taken;
    logic [23:0] branch_offset;
    logic        flag_n;
    logic        flag_z;

    logic [31:0] m_regs [16];   // Model state
    logic [31:0] m_mem [16];
    logic        m_flag_n;
    logic        m_flag_z;

    wb_event_t   wb_q [$];
    br_event_t   br_q [$];
    wb_event_t   wb_exp;
    br_event_t   br_exp;
    int          cycle_cnt = 0;
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          test_err_base = 0;
    integer      seed;
    logic [31:0] rnd;
    logic [31:0] ins;

    core_top core_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instruction   (instruction),
        .wb_valid      (wb_valid),
        .wb_reg        (wb_reg),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_offset (branch_offset),
        .flag_n        (flag_n),
        .flag_z        (flag_z)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] data_instr(input logic [3:0] opc, input logic imm,
                                               input logic [3:0] rn, input logic [3:0] rd,
                                               input logic [7:0] op2);
        return {COND_AL, TYPE_DATA, imm, opc, 1'b0, rn, rd, 4'h0, op2};
    endfunction

    function automatic logic [31:0] mem_instr(input logic load, input logic [3:0] rn,
                                              input logic [3:0] rd, input logic [7:0] imm8);
        return {COND_AL, TYPE_LOAD_STORE, 1'b1, 4'h0, load, rn, rd, 4'h0, imm8};
    endfunction

    // Expected outcome of one instruction, advancing the model state
    function automatic void ref_exec(input logic [31:0] i, output bit wb, output logic [3:0] rg,
                                     output logic [31:0] data, output bit br,
                                     output logic [23:0] off);
        logic [3:0]  rn;
        logic [3:0]  rm;
        logic [3:0]  opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] shifted;
        wb   = 1'b0;
        br   = 1'b0;
        rg   = i[15:12];
        data = '0;
        off  = i[23:0];
        rn   = i[19:16];
        rm   = i[3:0];
        opc  = i[24:21];
        a    = m_regs[rn];
        if (i == '0) begin
            return;   // NOP
        end
        case (i[27:26])
            TYPE_DATA: begin
                b = i[25] ? {24'h0, i[7:0]} : m_regs[rm];
                case (opc)
                    OPC_AND, OPC_ANDS: res = a & b;
                    OPC_SUB, OPC_SUBS: res = a - b;
                    OPC_LSL:           res = a << b[4:0];
                    default:           res = a + b;
                endcase
                if (opc == OPC_ANDS || opc == OPC_SUBS) begin
                    m_flag_n = res[31];
                    m_flag_z = (res == '0);
                end
                wb   = 1'b1;
                data = res;
            end
            TYPE_LOAD_STORE: begin
                addr = a + {24'h0, i[7:0]};
                if (i[20]) begin
                    shifted = m_mem[addr[5:2]] >> {addr[1:0], 3'b000};
                    wb      = 1'b1;
                    data    = {24'h0, shifted[7:0]};
                end else begin
                    m_mem[addr[5:2]] = m_regs[rg];   // Store reads rd
                end
            end
            TYPE_BRANCH: begin
                case (i[31:28])
                    COND_NE: br = !m_flag_z;
                    COND_LE: br = m_flag_z || m_flag_n;
                    COND_AL: br = 1'b1;
                    default: br = 1'b0;
                endcase
            end
            default: ;
        endcase
        if (wb) begin
            m_regs[rg] = data;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("ERR time=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // One instruction slot followed by two idle slots
    task automatic issue_instr(input logic [31:0] i);
        bit          wb;
        bit          br;
        logic [3:0]  rg;
        logic [31:0] data;
        logic [23:0] off;
        wb_event_t   we;
        br_event_t   be;
        ref_exec(i, wb, rg, data, br, off);
        if (wb) begin
            we.due  = cycle_cnt + 3;   // Report lands after acceptance edge + 2
            we.rg   = rg;
            we.data = data;
            wb_q.push_back(we);
        end
        if (br) begin
            be.due = cycle_cnt + 2;
            be.off = off;
            br_q.push_back(be);
        end
        instr_valid = 1'b1;
        instruction = i;
        @(negedge clk);
        instr_valid = 1'b0;
        repeat (2) begin
            instruction = $random(seed);   // Random bits, ignored while not valid
            @(negedge clk);
        end
        check_value("flag_n", 32'(m_flag_n), 32'(flag_n));
        check_value("flag_z", 32'(m_flag_z), 32'(flag_z));
    endtask

    task automatic finish_test(input string name, input int count);
        @(negedge clk);
        while (wb_q.size() > 0 || br_q.size() > 0) begin
            @(negedge clk);
        end
        $display("test %-8s %4d instructions, %0d errors", name, count, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // Outputs change on the rising edge, compared on the falling one
    always @(negedge clk) begin
        if (rst_n) begin
            if (wb_q.size() > 0 && wb_q[0].due == cycle_cnt) begin
                wb_exp = wb_q.pop_front();
                check_value("wb_valid", 32'd1, 32'(wb_valid));
                check_value("wb_reg", 32'(wb_exp.rg), 32'(wb_reg));
                check_value("wb_data", wb_exp.data, wb_data);
            end else begin
                check_value("wb_valid", 32'd0, 32'(wb_valid));
            end
            if (br_q.size() > 0 && br_q[0].due == cycle_cnt) begin
                br_exp = br_q.pop_front();
                check_value("branch_taken", 32'd1, 32'(branch_taken));
                check_value("branch_offset", 32'(br_exp.off), 32'(branch_offset));
            end else begin
                check_value("branch_taken", 32'd0, 32'(branch_taken));
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        seed        = 32'h5df4_4c63;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instruction = '0;
        m_flag_n    = 1'b0;
        m_flag_z    = 1'b0;
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = '0;
            m_mem[i]  = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        check_value("wb_valid", 32'd0, 32'(wb_valid));
        check_value("branch_taken", 32'd0, 32'(branch_taken));
        check_value("flag_n", 32'd0, 32'(flag_n));
        check_value("flag_z", 32'd0, 32'(flag_z));
        for (int i = 0; i < N_RESET; i++) begin
            issue_instr(data_instr(OPC_ADD, 1'b1, 4'(i), 4'(i), 8'h00));
        end
        finish_test("reset", N_RESET);

        for (int i = 0; i < N_DATA; i++) begin
            ins        = $random(seed);
            ins[27:26] = TYPE_DATA;   // Every opcode, default ones add
            issue_instr(ins);
        end
        finish_test("data", N_DATA);

        for (int i = 0; i < N_FLAGS; i++) begin
            rnd        = $random(seed);
            ins        = rnd;
            ins[27:26] = TYPE_DATA;
            case (rnd[30:28])
                3'd0, 3'd1: ins[24:21] = OPC_ANDS;
                3'd2, 3'd3: ins[24:21] = OPC_SUBS;
                3'd4:       ins[24:21] = OPC_ADD;
                3'd5:       ins[24:21] = OPC_SUB;
                3'd6:       ins[24:21] = OPC_AND;
                default:    ins[24:21] = OPC_LSL;
            endcase
            if (rnd[31]) begin
                ins[25]  = 1'b0;   // rm equal to rn gives zero results
                ins[3:0] = ins[19:16];
            end
            issue_instr(ins);
        end
        finish_test("flags", N_FLAGS);

        issue_instr(data_instr(OPC_AND, 1'b1, 4'd0, 4'd13, 8'h00));   // r13 base of zero
        for (int w = 0; w < 4; w++) begin
            issue_instr(mem_instr(1'b0, 4'd13, 4'(w + 1), 8'(w * 4)));
            for (int b = 0; b < 4; b++) begin
                issue_instr(mem_instr(1'b1, 4'd13, 4'(b + 5), 8'(w * 4 + b)));
            end
        end
        finish_test("memory", N_MEM);

        for (int i = 0; i < N_BRANCH; i++) begin
            rnd = $random(seed);
            ins = rnd;
            if (i % 2 == 0) begin
                ins[27:26] = TYPE_DATA;
                ins[24:21] = rnd[31] ? OPC_SUBS : OPC_ANDS;
                if (rnd[28]) begin
                    ins[25]  = 1'b0;
                    ins[3:0] = ins[19:16];
                end
            end else begin
                ins[27:26] = TYPE_BRANCH;
                case (rnd[25:24])
                    2'd0:    ins[31:28] = COND_NE;
                    2'd1:    ins[31:28] = COND_LE;
                    2'd2:    ins[31:28] = COND_AL;
                    default: ;   // Random condition, mostly never taken
                endcase
            end
            issue_instr(ins);
        end
        finish_test("branch", N_BRANCH);

        for (int i = 0; i < N_QUIET; i++) begin
            ins        = $random(seed);
            ins[27:26] = 2'b11;
            issue_instr((i % 2 == 0) ? 32'h0 : ins);
        end
        finish_test("quiet", N_QUIET);

        for (int i = 0; i < N_RANDOM; i++) begin
            ins = $random(seed);
            issue_instr(ins);
        end
        finish_test("random", N_RANDOM);

        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* core.f */
rtl/core_pkg.sv
rtl/control_unit.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core_top.sv
testbench/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= core.f
TB_TOP    ?= core_tb
RTL_TOP   ?= core_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "FAIL: no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
